// File: fetch_pkg.sv
package fetch_pkg;

  // Datapath widths
  localparam int NB_ADDR        = 32;                         // Byte address width
  localparam int NB_INSTRUCTION = 32;
  localparam int NB_BYTE        = 8;                          // Memory word is one byte
  localparam int BYTES_PER_WORD = NB_INSTRUCTION / NB_BYTE;   // Also the pc step

  localparam int MEMORY_DEPTH   = 256;                        // Bytes of program space
  localparam int NB_MEM_ADDR    = $clog2(MEMORY_DEPTH);       // Index bits, address wraps

  // AXI4-Lite host port
  localparam int NB_AXI_DATA = 32;
  localparam int NB_AXI_STRB = NB_AXI_DATA / 8;
  localparam int NB_RESP     = 2;
  localparam logic [NB_RESP-1:0] RESP_OKAY   = 2'b00;
  localparam logic [NB_RESP-1:0] RESP_SLVERR = 2'b10;

  // Register map, byte offsets
  localparam logic [NB_ADDR-1:0] REG_CTRL      = 32'h0000_0000;
  localparam logic [NB_ADDR-1:0] REG_PROG_ADDR = 32'h0000_0004;
  localparam logic [NB_ADDR-1:0] REG_PROG_DATA = 32'h0000_0008;
  localparam logic [NB_ADDR-1:0] REG_STATUS    = 32'h0000_000C;
  localparam logic [NB_ADDR-1:0] REG_PC        = 32'h0000_0010;

  localparam int CTRL_RUN_BIT     = 0;     // Start pulse
  localparam int CTRL_CLEAR_BIT   = 1;     // Back to idle, pc zero
  localparam int NB_COUNT         = 8;     // Loaded byte counter
  localparam int STATUS_COUNT_LSB = 8;     // Counter sits at STATUS[15:8]

  localparam int NB_OPCODE = 6;
  localparam int NB_STATE  = 2;

  // Top six bits of the instruction
  typedef enum logic [NB_OPCODE-1:0] {
    op_special = 6'h00,
    op_halt    = 6'h3f
  } opcode_e;

  typedef enum logic [NB_STATE-1:0] {
    st_idle   = 2'd0,
    st_run    = 2'd1,
    st_halted = 2'd2
  } fetch_state_e;

endpackage

// File: fetch_subsystem.f
fetch_pkg.sv
imem_write_if.sv
instruction_memory.sv
program_loader.sv
fetch_unit.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv

// File: fetch_subsystem.sv
module fetch_subsystem (
  input  logic                                  i_clock,
  input  logic                                  i_rst_n,
  // Host AXI4-Lite
  input  logic [fetch_pkg::NB_ADDR-1:0]         i_awaddr,
  input  logic                                  i_awvalid,
  output logic                                  o_awready,
  input  logic [fetch_pkg::NB_AXI_DATA-1:0]     i_wdata,
  input  logic [fetch_pkg::NB_AXI_STRB-1:0]     i_wstrb,
  input  logic                                  i_wvalid,
  output logic                                  o_wready,
  output logic [fetch_pkg::NB_RESP-1:0]         o_bresp,
  output logic                                  o_bvalid,
  input  logic                                  i_bready,
  input  logic [fetch_pkg::NB_ADDR-1:0]         i_araddr,
  input  logic                                  i_arvalid,
  output logic                                  o_arready,
  output logic [fetch_pkg::NB_AXI_DATA-1:0]     o_rdata,
  output logic [fetch_pkg::NB_RESP-1:0]         o_rresp,
  output logic                                  o_rvalid,
  input  logic                                  i_rready,
  // Instruction stream toward decode
  output logic [fetch_pkg::NB_INSTRUCTION-1:0]  o_instr,
  output logic [fetch_pkg::NB_ADDR-1:0]         o_instr_pc,
  output logic                                  o_instr_valid,
  input  logic                                  i_instr_ready
);

  logic                                 start;
  logic                                 clear;
  fetch_pkg::fetch_state_e              state;
  logic [fetch_pkg::NB_ADDR-1:0]        pc;
  logic                                 rd_en;
  logic                                 rd_hold;
  logic [fetch_pkg::NB_ADDR-1:0]        rd_addr;
  logic [fetch_pkg::NB_INSTRUCTION-1:0] rd_data;

  imem_write_if imem_wr ();   // Loader to memory byte writes

  program_loader u_loader (
    .i_clock   (i_clock),   .i_rst_n   (i_rst_n),
    .i_awaddr  (i_awaddr),  .i_awvalid (i_awvalid), .o_awready (o_awready),
    .i_wdata   (i_wdata),   .i_wstrb   (i_wstrb),   .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),  .o_bresp   (o_bresp),   .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),  .i_araddr  (i_araddr),  .i_arvalid (i_arvalid),
    .o_arready (o_arready), .o_rdata   (o_rdata),   .o_rresp   (o_rresp),
    .o_rvalid  (o_rvalid),  .i_rready  (i_rready),  .wr_port   (imem_wr.loader),
    .o_start   (start),     .o_clear   (clear),     .i_state   (state),
    .i_pc      (pc)
  );

  instruction_memory u_imem (
    .i_clock   (i_clock),   .i_rst_n   (i_rst_n),   .wr_port   (imem_wr.memory),
    .i_rd_en   (rd_en),     .i_rd_hold (rd_hold),   .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  fetch_unit u_fetch (
    .i_clock   (i_clock),   .i_rst_n   (i_rst_n),
    .i_start   (start),     .i_clear   (clear),
    .o_state   (state),     .o_pc      (pc),
    .o_rd_en   (rd_en),     .o_rd_hold (rd_hold),   .o_rd_addr (rd_addr),
    .i_rd_data (rd_data),
    .o_instr       (o_instr),
    .o_instr_pc    (o_instr_pc),
    .o_instr_valid (o_instr_valid),
    .i_instr_ready (i_instr_ready)
  );

endmodule

// File: fetch_unit.sv
module fetch_unit (
  input  logic                                  i_clock,
  input  logic                                  i_rst_n,
  input  logic                                  i_start,
  input  logic                                  i_clear,
  output fetch_pkg::fetch_state_e               o_state,
  output logic [fetch_pkg::NB_ADDR-1:0]         o_pc,
  output logic                                  o_rd_en,
  output logic                                  o_rd_hold,
  output logic [fetch_pkg::NB_ADDR-1:0]         o_rd_addr,
  input  logic [fetch_pkg::NB_INSTRUCTION-1:0]  i_rd_data,
  output logic [fetch_pkg::NB_INSTRUCTION-1:0]  o_instr,
  output logic [fetch_pkg::NB_ADDR-1:0]         o_instr_pc,
  output logic                                  o_instr_valid,
  input  logic                                  i_instr_ready
);

  fetch_pkg::fetch_state_e         state;
  fetch_pkg::opcode_e              out_opcode;
  logic [fetch_pkg::NB_ADDR-1:0]   pc;         // Next address to issue
  logic [fetch_pkg::NB_ADDR-1:0]   out_pc;     // Address of the word at the output
  logic                            out_valid;
  logic                            stall;
  logic                            accept;
  logic                            issue;
  logic                            halt_seen;

  assign out_opcode = fetch_pkg::opcode_e'(
    i_rd_data[fetch_pkg::NB_INSTRUCTION-1 -: fetch_pkg::NB_OPCODE]);
  assign stall     = out_valid && !i_instr_ready;         // Decode is not taking it
  assign accept    = out_valid && i_instr_ready;
  assign halt_seen = accept && (out_opcode == fetch_pkg::op_halt);
  assign issue     = (state == fetch_pkg::st_run) && !stall;

  assign o_rd_en       = (state == fetch_pkg::st_run);
  assign o_rd_hold     = stall;                           // Memory keeps the output word
  assign o_rd_addr     = pc;
  assign o_instr       = i_rd_data;                       // Memory register is the output stage
  assign o_instr_pc    = out_pc;
  assign o_instr_valid = out_valid;
  assign o_state       = state;
  assign o_pc          = pc;

  always_ff @(posedge i_clock) begin
    if (!i_rst_n || i_clear) begin
      state     <= fetch_pkg::st_idle;
      pc        <= '0;
      out_valid <= 1'b0;
    end else if (i_start) begin
      state     <= fetch_pkg::st_run;                     // Also restarts from halted
      pc        <= '0;
      out_valid <= 1'b0;
    end else begin
      if (issue) pc <= pc + fetch_pkg::NB_ADDR'(fetch_pkg::BYTES_PER_WORD);
      if (halt_seen) begin
        state     <= fetch_pkg::st_halted;
        out_valid <= 1'b0;                                // Word behind the halt is dropped
      end else if (issue) begin
        out_valid <= 1'b1;
      end
    end
  end

  // Track which pc the memory register holds
  always_ff @(posedge i_clock) begin
    if (issue) out_pc <= pc;
  end

  a_stall_stable: assert property (
    @(posedge i_clock) disable iff (!i_rst_n)
    (o_instr_valid && !i_instr_ready && !i_clear && !i_start) |=>
      (o_instr_valid && $stable(o_instr) && $stable(o_instr_pc))
  ) else $error("Instruction output changed while stalled");

endmodule

// File: imem_write_if.sv
interface imem_write_if;

  logic                            wr_en;    // One byte per strobe
  logic [fetch_pkg::NB_MEM_ADDR-1:0] wr_addr;  // Memory index
  logic [fetch_pkg::NB_BYTE-1:0]     wr_data;

  // Loader side
  modport loader (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  // Memory side
  modport memory (
    input wr_en,
    input wr_addr,
    input wr_data
  );

endinterface

// File: instruction_memory.sv
module instruction_memory (
  input  logic                                  i_clock,
  input  logic                                  i_rst_n,
  imem_write_if.memory                          wr_port,
  input  logic                                  i_rd_en,
  input  logic                                  i_rd_hold,    // Keep last word while stalled
  input  logic [fetch_pkg::NB_ADDR-1:0]         i_rd_addr,
  output logic [fetch_pkg::NB_INSTRUCTION-1:0]  o_rd_data
);

  logic [fetch_pkg::NB_BYTE-1:0]        mem [fetch_pkg::MEMORY_DEPTH];
  logic [fetch_pkg::NB_MEM_ADDR-1:0]    rd_idx;
  logic [fetch_pkg::NB_MEM_ADDR-1:0]    byte_idx [fetch_pkg::BYTES_PER_WORD];
  logic [fetch_pkg::NB_INSTRUCTION-1:0] rd_word;

  // Program space starts cleared
  initial begin
    for (int i = 0; i < fetch_pkg::MEMORY_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign rd_idx = i_rd_addr[fetch_pkg::NB_MEM_ADDR-1:0];  // Upper address bits ignored

  // Four consecutive bytes, first byte lands in the top lane
  always_comb begin
    for (int b = 0; b < fetch_pkg::BYTES_PER_WORD; b++) begin
      byte_idx[b] = rd_idx + fetch_pkg::NB_MEM_ADDR'(b);    // Wraps at the end of memory
      rd_word[fetch_pkg::NB_INSTRUCTION-1-fetch_pkg::NB_BYTE*b -: fetch_pkg::NB_BYTE] =
        mem[byte_idx[b]];
    end
  end

  always_ff @(posedge i_clock) begin
    if (wr_port.wr_en) begin
      mem[wr_port.wr_addr] <= wr_port.wr_data;
    end
  end

  // Registered read port, one cycle latency
  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      o_rd_data <= '0;
    end else if (!i_rd_en) begin
      o_rd_data <= '0;                                     // Disabled port reads zero
    end else if (!i_rd_hold) begin
      o_rd_data <= rd_word;
    end
  end

  // Loader must never touch the word the fetch side is sampling
  a_no_wr_rd_collision: assert property (
    @(posedge i_clock) disable iff (!i_rst_n)
    (wr_port.wr_en && i_rd_en && !i_rd_hold) |->
      (wr_port.wr_addr[fetch_pkg::NB_MEM_ADDR-1:2] != rd_idx[fetch_pkg::NB_MEM_ADDR-1:2])
  ) else $error("Byte write hit the word being fetched");

endmodule

// File: program_loader.sv
module program_loader (
  input  logic                               i_clock,
  input  logic                               i_rst_n,
  // AXI4-Lite slave
  input  logic [fetch_pkg::NB_ADDR-1:0]      i_awaddr,
  input  logic                               i_awvalid,
  output logic                               o_awready,
  input  logic [fetch_pkg::NB_AXI_DATA-1:0]  i_wdata,
  input  logic [fetch_pkg::NB_AXI_STRB-1:0]  i_wstrb,
  input  logic                               i_wvalid,
  output logic                               o_wready,
  output logic [fetch_pkg::NB_RESP-1:0]      o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,
  input  logic [fetch_pkg::NB_ADDR-1:0]      i_araddr,
  input  logic                               i_arvalid,
  output logic                               o_arready,
  output logic [fetch_pkg::NB_AXI_DATA-1:0]  o_rdata,
  output logic [fetch_pkg::NB_RESP-1:0]      o_rresp,
  output logic                               o_rvalid,
  input  logic                               i_rready,
  // Byte writes toward memory
  imem_write_if.loader                       wr_port,
  // Fetch unit control and status
  output logic                               o_start,
  output logic                               o_clear,
  input  fetch_pkg::fetch_state_e            i_state,
  input  logic [fetch_pkg::NB_ADDR-1:0]      i_pc
);

  logic                                 aw_hs;       // AW and W accepted together
  logic                                 ar_hs;
  logic                                 prog_busy;   // Fetching, program is locked
  logic                                 wr_okay;
  logic                                 rd_okay;
  logic [fetch_pkg::NB_AXI_DATA-1:0]    rd_word;
  logic [fetch_pkg::NB_ADDR-1:0]        prog_addr;
  logic [fetch_pkg::NB_COUNT-1:0]       byte_count;
  logic                                 wr_en_q;
  logic [fetch_pkg::NB_MEM_ADDR-1:0]    wr_addr_q;
  logic [fetch_pkg::NB_BYTE-1:0]        wr_data_q;

  assign aw_hs     = i_awvalid && i_wvalid && !o_bvalid;  // One at a time
  assign o_awready = aw_hs;
  assign o_wready  = aw_hs;
  assign ar_hs     = i_arvalid && o_arready;
  assign o_arready = !o_rvalid;                           // Free while no response waits
  assign prog_busy = (i_state == fetch_pkg::st_run);

  // Byte write goes out the cycle after acceptance
  assign wr_port.wr_en   = wr_en_q;
  assign wr_port.wr_addr = wr_addr_q;
  assign wr_port.wr_data = wr_data_q;

  // Write response decode
  always_comb begin
    case (i_awaddr)
      fetch_pkg::REG_CTRL,
      fetch_pkg::REG_PROG_ADDR,
      fetch_pkg::REG_STATUS,
      fetch_pkg::REG_PC:        wr_okay = 1'b1;      // Read-only ones ignore the data
      fetch_pkg::REG_PROG_DATA: wr_okay = !prog_busy;
      default:                  wr_okay = 1'b0;
    endcase
  end

  // Read mux
  always_comb begin
    rd_okay = 1'b1;
    rd_word = '0;
    case (i_araddr)
      fetch_pkg::REG_CTRL,
      fetch_pkg::REG_PROG_DATA: rd_word = '0;        // Write-only
      fetch_pkg::REG_PROG_ADDR: rd_word = prog_addr;
      fetch_pkg::REG_STATUS: begin
        rd_word[fetch_pkg::NB_STATE-1:0]                            = i_state;
        rd_word[fetch_pkg::STATUS_COUNT_LSB +: fetch_pkg::NB_COUNT] = byte_count;
      end
      fetch_pkg::REG_PC:        rd_word = i_pc;
      default:                  rd_okay = 1'b0;      // Unmapped, reads zero
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      o_bvalid   <= 1'b0;
      o_start    <= 1'b0;
      o_clear    <= 1'b0;
      wr_en_q    <= 1'b0;
      prog_addr  <= '0;
      byte_count <= '0;
    end else begin
      o_start <= 1'b0;                               // Pulses last one cycle
      o_clear <= 1'b0;
      wr_en_q <= 1'b0;
      if (aw_hs) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (aw_hs) begin
        case (i_awaddr)
          fetch_pkg::REG_CTRL: begin
            o_start <= i_wstrb[0] && i_wdata[fetch_pkg::CTRL_RUN_BIT];
            o_clear <= i_wstrb[0] && i_wdata[fetch_pkg::CTRL_CLEAR_BIT];
          end
          fetch_pkg::REG_PROG_ADDR: begin
            for (int b = 0; b < fetch_pkg::NB_AXI_STRB; b++) begin
              if (i_wstrb[b]) prog_addr[8*b +: 8] <= i_wdata[8*b +: 8];
            end
          end
          fetch_pkg::REG_PROG_DATA: begin
            if (!prog_busy && i_wstrb[0]) begin
              wr_en_q    <= 1'b1;
              prog_addr  <= prog_addr + 1'b1;        // Auto-increment per byte
              byte_count <= byte_count + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Read response valid
  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      o_rvalid <= 1'b0;
    end else if (ar_hs) begin
      o_rvalid <= 1'b1;
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  // Response and byte payloads
  always_ff @(posedge i_clock) begin
    if (aw_hs) begin
      o_bresp   <= wr_okay ? fetch_pkg::RESP_OKAY : fetch_pkg::RESP_SLVERR;
      wr_addr_q <= prog_addr[fetch_pkg::NB_MEM_ADDR-1:0];
      wr_data_q <= i_wdata[fetch_pkg::NB_BYTE-1:0];     // Low byte only
    end
    if (ar_hs) begin
      o_rdata <= rd_word;
      o_rresp <= rd_okay ? fetch_pkg::RESP_OKAY : fetch_pkg::RESP_SLVERR;
    end
  end

  a_bvalid_hold: assert property (
    @(posedge i_clock) disable iff (!i_rst_n)
    (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bresp))
  ) else $error("Write response changed before bready");

  a_rvalid_hold: assert property (
    @(posedge i_clock) disable iff (!i_rst_n)
    (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata) && $stable(o_rresp))
  ) else $error("Read response changed before rready");

endmodule

// File: tb_fetch_subsystem.sv
module tb_fetch_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_WORDS      = 17;                   // 16 random words plus the halt
  localparam int PROG_BYTES      = PROG_WORDS * 4;
  localparam int WATCHDOG_CYCLES = PROG_WORDS * 20 + 2000;
  localparam int HS_LIMIT        = 50;                   // Cycles allowed per bus response

  logic        i_clock = 1'b0;
  logic        i_rst_n;
  logic [31:0] i_awaddr;
  logic        i_awvalid;
  logic        o_awready;
  logic [31:0] i_wdata;
  logic [3:0]  i_wstrb;
  logic        i_wvalid;
  logic        o_wready;
  logic [1:0]  o_bresp;
  logic        o_bvalid;
  logic        i_bready;
  logic [31:0] i_araddr;
  logic        i_arvalid;
  logic        o_arready;
  logic [31:0] o_rdata;
  logic [1:0]  o_rresp;
  logic        o_rvalid;
  logic        i_rready;
  logic [31:0] o_instr;
  logic [31:0] o_instr_pc;
  logic        o_instr_valid;
  logic        i_instr_ready;

  logic [7:0]  mirror [256];                  // Host copy of program space
  logic [31:0] rng_state = 32'h9d66_3442;
  bit          throttle  = 1'b0;              // Random ready toward the DUT
  bit          halt_done = 1'b0;
  logic [31:0] exp_pc    = '0;                // Next pc expected on the stream
  logic [31:0] halt_pc   = '0;
  int          fail_count = 0;

  fetch_subsystem uut (.*);

  initial begin
    forever #5 i_clock = ~i_clock;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge i_clock);
    $display("Watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $fatal(1);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected word, first byte in the top lane, index wraps at 256
  function automatic logic [31:0] ref_instr(input logic [31:0] pc);
    logic [31:0] word;
    logic [7:0]  idx;
    word = '0;
    for (int k = 0; k < 4; k++) begin
      idx  = pc[7:0] + 8'(k);
      word = {word[23:0], mirror[idx]};
    end
    return word;
  endfunction

  function automatic logic [31:0] status_word(input logic [1:0] state, input int count);
    return {16'h0, 8'(count), 6'h0, state};     // Count in 15:8, state in 1:0
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_count++;
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int waited;
    waited = 0;
    @(negedge i_clock);
    i_awaddr  = addr;
    i_awvalid = 1'b1;
    i_wdata   = data;
    i_wstrb   = 4'hf;
    i_wvalid  = 1'b1;
    i_bready  = 1'b1;
    do begin
      @(negedge i_clock);
      waited++;
      if (waited > HS_LIMIT) abort_run($sformatf("No write response at offset %h", addr));
    end while (!o_bvalid);
    resp      = o_bresp;                      // Held until the next edge takes bready
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    waited = 0;
    @(negedge i_clock);
    i_araddr  = addr;
    i_arvalid = 1'b1;
    i_rready  = 1'b1;
    do begin
      @(negedge i_clock);
      waited++;
      if (waited > HS_LIMIT) abort_run($sformatf("No read response at offset %h", addr));
    end while (!o_rvalid);
    data      = o_rdata;
    resp      = o_rresp;
    i_arvalid = 1'b0;
  endtask

  task automatic write_expect(input logic [31:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_value("o_bresp", 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] expected,
                             input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_value("o_rresp", 32'(fetch_pkg::RESP_OKAY), 32'(resp));
    check_value(name, expected, data);
  endtask

  // Flags change on the rising edge, the stream process works on the falling one
  task automatic arm_stream(input bit random_ready);
    @(posedge i_clock);
    throttle  = random_ready;
    halt_done = 1'b0;
    exp_pc    = '0;
  endtask

  task automatic wait_for_halt();
    int waited;
    waited = 0;
    while (!halt_done) begin
      @(posedge i_clock);
      waited++;
      if (waited > PROG_WORDS * 20) abort_run("Halt word never reached the decode side");
    end
  endtask

  // Drives ready and checks every word that the next rising edge accepts
  initial begin : stream_check
    logic        take;
    logic [31:0] expected;
    forever begin
      @(negedge i_clock);
      if (throttle) begin
        rng_state = xorshift32(rng_state);
        take      = (rng_state[1:0] != 2'b00);  // Ready about three cycles in four
      end else begin
        take = 1'b1;
      end
      i_instr_ready = take;
      if (halt_done) begin
        check_value("o_instr_valid", 32'd0, 32'(o_instr_valid));  // Nothing behind the halt
      end else if (o_instr_valid && take) begin
        expected = ref_instr(exp_pc);
        check_value("o_instr_pc", exp_pc, o_instr_pc);
        check_value("o_instr", expected, o_instr);
        if (expected[31:26] == 6'h3f) begin     // Halt opcode, all ones
          halt_done = 1'b1;
          halt_pc   = exp_pc;
        end
        exp_pc += 4;
      end
    end
  end

  initial begin : test_sequence
    logic [31:0] word;
    logic [31:0] data;
    logic [1:0]  resp;
    i_rst_n       = 1'b0;
    i_awaddr      = '0;
    i_awvalid     = 1'b0;
    i_wdata       = '0;
    i_wstrb       = '0;
    i_wvalid      = 1'b0;
    i_bready      = 1'b0;
    i_araddr      = '0;
    i_arvalid     = 1'b0;
    i_rready      = 1'b0;
    i_instr_ready = 1'b1;
    for (int i = 0; i < 256; i++) mirror[i] = '0;
    repeat (8) @(negedge i_clock);
    i_rst_n = 1'b1;
    @(negedge i_clock);
    check_value("o_awready", 32'd0, 32'(o_awready));
    check_value("o_wready", 32'd0, 32'(o_wready));
    check_value("o_arready", 32'd1, 32'(o_arready));
    check_value("o_bvalid", 32'd0, 32'(o_bvalid));
    check_value("o_rvalid", 32'd0, 32'(o_rvalid));
    check_value("o_instr_valid", 32'd0, 32'(o_instr_valid));
    read_expect(fetch_pkg::REG_STATUS, 32'd0, "o_rdata STATUS");
    read_expect(fetch_pkg::REG_PC, 32'd0, "o_rdata PC");
    read_expect(fetch_pkg::REG_PROG_ADDR, 32'd0, "o_rdata PROG_ADDR");

    // Load 16 random words and the halt, one byte per write
    write_expect(fetch_pkg::REG_PROG_ADDR, 32'd0, fetch_pkg::RESP_OKAY);
    for (int w = 0; w < PROG_WORDS; w++) begin
      rng_state = xorshift32(rng_state);
      word      = rng_state;
      if (w == PROG_WORDS - 1) word[31:26] = 6'h3f;
      else word[31] = 1'b0;                     // Keeps random words off the halt opcode
      for (int b = 0; b < 4; b++) begin
        mirror[4*w+b] = word[31-8*b -: 8];
        write_expect(fetch_pkg::REG_PROG_DATA, {24'h0, mirror[4*w+b]}, fetch_pkg::RESP_OKAY);
      end
    end
    read_expect(fetch_pkg::REG_STATUS, status_word(fetch_pkg::st_idle, PROG_BYTES),
                "o_rdata STATUS");
    read_expect(fetch_pkg::REG_PC, 32'd0, "o_rdata PC");
    read_expect(fetch_pkg::REG_PROG_ADDR, 32'(PROG_BYTES), "o_rdata PROG_ADDR");

    // Full-speed stream up to the halt
    arm_stream(1'b0);
    write_expect(fetch_pkg::REG_CTRL, 32'h1, fetch_pkg::RESP_OKAY);
    wait_for_halt();
    read_expect(fetch_pkg::REG_STATUS, status_word(fetch_pkg::st_halted, PROG_BYTES),
                "o_rdata STATUS");
    read_expect(fetch_pkg::REG_PC, halt_pc + 32'd8, "o_rdata PC");  // Past the word behind halt

    // Restart from halted under back-pressure, program write refused while running
    arm_stream(1'b1);
    write_expect(fetch_pkg::REG_CTRL, 32'h1, fetch_pkg::RESP_OKAY);
    write_expect(fetch_pkg::REG_PROG_DATA, 32'h0000_00a5, fetch_pkg::RESP_SLVERR);
    wait_for_halt();
    read_expect(fetch_pkg::REG_STATUS, status_word(fetch_pkg::st_halted, PROG_BYTES),
                "o_rdata STATUS");
    read_expect(fetch_pkg::REG_PC, halt_pc + 32'd8, "o_rdata PC");

    // Unmapped offset
    write_expect(32'h0000_0020, 32'h1, fetch_pkg::RESP_SLVERR);
    axi_read(32'h0000_0020, data, resp);
    check_value("o_rresp", 32'(fetch_pkg::RESP_SLVERR), 32'(resp));
    check_value("o_rdata unmapped", 32'd0, data);

    // Clear, then replay from zero
    write_expect(fetch_pkg::REG_CTRL, 32'h2, fetch_pkg::RESP_OKAY);
    read_expect(fetch_pkg::REG_STATUS, status_word(fetch_pkg::st_idle, PROG_BYTES),
                "o_rdata STATUS");
    read_expect(fetch_pkg::REG_PC, 32'd0, "o_rdata PC");
    arm_stream(1'b1);
    write_expect(fetch_pkg::REG_CTRL, 32'h1, fetch_pkg::RESP_OKAY);
    wait_for_halt();
    read_expect(fetch_pkg::REG_STATUS, status_word(fetch_pkg::st_halted, PROG_BYTES),
                "o_rdata STATUS");

    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
